//--- video_top.f
+incdir+source
source/vic_pkg.sv
source/raster_gen.sv
source/line_buffer.sv
source/vga_sync.sv
source/comp_sync.sv
source/color.sv
source/video_top.sv
tb/video_top_asserts.sv
tb/video_top_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = video_top_tb
FILELIST  = video_top.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/video_top_tb.sv
`timescale 1ns/1ps

`include "vic_defines.svh"

module video_top_tb;
    import vic_pkg::*;

    logic                clk_dot4x = 1'b0;
    logic                rst_n;
    logic                is_composite;
    chip_t               chip;
    logic [3:0]          border_color;
    logic                csync;
    logic                hsync;
    logic                vsync;
    logic                active;
    logic [2:0]          red;
    logic [2:0]          green;
    logic [2:0]          blue;
    logic [`X_BITS-1:0]  raster_x;
    logic [`Y_BITS-1:0]  raster_line;

    integer              seed = 32'h80c5;
    int                  checks = 0;
    int                  errors = 0;
    int                  timeouts = 0;
    int                  line_cyc;          // cycles in the last measured line
    int                  low_cnt [4];       // csync, hsync, vsync, active inverted
    int                  falls [4];
    int                  max_run [4];       // longest low stretch
    logic                mid [4];           // level at mid line

    // c64 colours as octal {r, g, b}
    logic [8:0] palette [16] = '{9'o000, 9'o777, 9'o400, 9'o577, 9'o626, 9'o062, 9'o005,
                                 9'o773, 9'o642, 9'o320, 9'o733, 9'o111, 9'o333, 9'o573,
                                 9'o047, 9'o555};

    video_top i_video_top (.*);

    always #5 clk_dot4x = ~clk_dot4x;      // 10 ns period

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic check(input int expected, input int actual, input string msg);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("FAILED at %0t: %s, expected %0d got %0d", $time, msg, expected, actual);
        end
    endtask

    function automatic logic sync_level(input int sel);
        case (sel)
            0:       return csync;
            1:       return hsync;
            2:       return vsync;
            default: return ~active;        // so active time counts as low
        endcase
    endfunction

    // blanking, window pattern or border
    function automatic int comp_index(input int x, input int y, input int border);
        if (y < `VISIBLE_Y_START || (x >= `HSYNC_START && x < `HSYNC_START + `HSYNC_LEN))
            return 0;
        if (x >= `WIN_X_START && x <= `WIN_X_END && y >= `WIN_Y_START && y <= `WIN_Y_END)
            return (x / 8 + y) % 16;
        return border;
    endfunction

    task automatic wait_line_change();
        logic [`Y_BITS-1:0] start;
        int n;
        start = raster_line;
        n = 0;
        while (raster_line == start && n < 2200) begin
            @(negedge clk_dot4x);
            n++;
        end
        if (raster_line == start) begin
            $display("timeout: raster line %0d never ended", start);
            timeouts++;
        end
    endtask

    // returns on the first cycle of line y
    task automatic wait_for_line(input int y);
        int n;
        n = 0;
        while (raster_line != y && n < 700000) begin
            @(negedge clk_dot4x);
            n++;
        end
        if (raster_line != y) begin
            $display("timeout: raster line %0d was never reached", y);
            timeouts++;
        end
    endtask

    // level statistics of the four sync signals over one source line
    task automatic measure_line();
        logic [`Y_BITS-1:0] start;
        logic prev [4];
        int   run [4];
        start = raster_line;
        line_cyc = 0;
        for (int i = 0; i < 4; i++) begin
            prev[i]    = sync_level(i);
            low_cnt[i] = 0;
            falls[i]   = 0;
            max_run[i] = 0;
            run[i]     = 0;
            mid[i]     = 1'b1;
        end
        while (raster_line == start && line_cyc < 2200) begin
            for (int i = 0; i < 4; i++) begin
                run[i] = sync_level(i) ? 0 : run[i] + 1;
                low_cnt[i] += sync_level(i) ? 0 : 1;
                if (run[i] > max_run[i]) max_run[i] = run[i];
                if (prev[i] && !sync_level(i)) falls[i]++;   // falling edge
                if (raster_x == 252) mid[i] = sync_level(i);
                prev[i] = sync_level(i);
            end
            line_cyc++;
            @(negedge clk_dot4x);
        end
        if (raster_line == start) begin
            $display("timeout: line %0d did not end while measuring sync", start);
            timeouts++;
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic apply_reset(input chip_t model);
        @(negedge clk_dot4x);
        rst_n = 1'b0;
        chip  = model;                      // only changes inside reset
        repeat (5) @(negedge clk_dot4x);
        check(1, hsync, "hsync in reset");
        check(1, vsync, "vsync in reset");
        check(1, csync, "csync in reset");
        check(0, active, "active in reset");
        check(0, raster_x + raster_line, "raster counters in reset");
        rst_n = 1'b1;
        @(negedge clk_dot4x);
        check(1, hsync & vsync, "hsync and vsync after reset");
        check(0, active, "active after reset");
        check(0, raster_line, "raster_line after reset");
        repeat (3) @(negedge clk_dot4x);
        check(0, raster_x, "raster_x during first dot");
        @(negedge clk_dot4x);
        check(1, raster_x, "raster_x after one dot");  // dot is 4 cycles
    endtask

    task automatic geometry_check(input int dots, input int lines);
        wait_line_change();
        measure_line();
        check(dots * 4, line_cyc, "cycles per source line");
        wait_for_line(lines - 1);
        wait_line_change();
        check(0, raster_line, "raster line wrap");
    endtask

    task automatic composite_pixels(input int last_line);
        logic [`X_BITS-1:0] prev_x;
        int cnt;
        int n;
        is_composite = 1'b1;
        border_color = 4'($random(seed));
        prev_x = raster_x;
        cnt = 3;                            // skip the partial first dot
        n = 0;
        while (raster_line != last_line && n < (last_line + 1) * 2016) begin
            @(negedge clk_dot4x);
            n++;
            cnt = (raster_x != prev_x) ? 0 : cnt + 1;
            prev_x = raster_x;
            if (cnt == 2) begin             // third cycle of the dot
                check(palette[comp_index(raster_x, raster_line, border_color)],
                      {red, green, blue},
                      $sformatf("composite pixel x %0d line %0d", raster_x, raster_line));
            end
        end
        if (raster_line != last_line) begin
            $display("timeout: composite scan never reached line %0d", last_line);
            timeouts++;
        end
    endtask

    // pal lines from the current one on, across the frame wrap
    task automatic sync_lines(input int count);
        int   y;
        logic visible;
        repeat (count) begin
            y = raster_line;
            visible = (y >= `VISIBLE_Y_START) && (y <= `VISIBLE_Y_END);
            measure_line();
            check(`PAL_DOTS_PER_LINE * 4, line_cyc, $sformatf("cycles on line %0d", y));
            if (y < `VSYNC_LEN) begin
                check(1, int'(low_cnt[0] > `PAL_DOTS_PER_LINE * 2),
                      $sformatf("csync mostly low on line %0d", y));
            end else begin
                check(1, falls[0], $sformatf("csync pulses on line %0d", y));
                check(`HSYNC_LEN * 4, max_run[0], $sformatf("csync width on line %0d", y));
            end
            check(2, falls[1], $sformatf("hsync pulses on line %0d", y));
            check(`HSYNC_LEN * 2, max_run[1], $sformatf("hsync width on line %0d", y));
            check(y >= `VSYNC_LEN, mid[2], $sformatf("vsync level on line %0d", y));
            check(visible ? `VISIBLE_X * 4 : 0, low_cnt[3],
                  $sformatf("active cycles on line %0d", y));
            if (visible) check(`VISIBLE_X * 2, max_run[3], "active width per vga line");
            if (y == `PAL_LINES - 1) check(0, raster_line, "pal raster line wrap");
        end
    endtask

    task automatic vga_line(input logic [3:0] color_idx);
        logic [`Y_BITS-1:0] start;
        int samples;
        int n;
        start = raster_line;
        samples = 0;
        n = 0;
        while (raster_line == start && n < 2200) begin
            if (active) begin
                samples++;
                check(palette[color_idx], {red, green, blue},
                      $sformatf("vga border pixel on line %0d", start));
            end
            n++;
            @(negedge clk_dot4x);
        end
        check(`VISIBLE_X * 4, samples, "active samples on a border line");
        if (raster_line == start) begin
            $display("timeout: vga line %0d did not end", start);
            timeouts++;
        end
    endtask

    task automatic vga_border_change();
        logic [3:0] new_color;
        is_composite = 1'b0;
        wait_for_line(30);                  // shows line 29, above the window
        vga_line(border_color);
        new_color = border_color ^ 4'(($random(seed) & 7) + 1);   // always differs
        border_color = new_color;
        wait_line_change();
        wait_line_change();
        vga_line(new_color);                // second line after the change
    endtask

    // ----------------------------------------------------------------------
    // sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n        = 1'b0;
        is_composite = 1'b1;
        chip         = CHIP_6569_PAL;
        border_color = 4'd0;
        apply_reset(CHIP_6567_NTSC);
        geometry_check(`NTSC_DOTS_PER_LINE, `NTSC_LINES);
        apply_reset(CHIP_6569_PAL);
        composite_pixels(56);               // blank, border and window lines
        wait_for_line(`PAL_LINES - 2);
        sync_lines(20);
        vga_border_change();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : video_top_tb

//--- tb/video_top_asserts.sv
`timescale 1ns/1ps

`include "vic_defines.svh"

module video_top_asserts (
    input logic clk_dot4x,
    input logic rst_n,
    input logic hsync,
    input logic vsync,
    input logic csync,
    input logic active
);

    logic [7:0] low_run;    // hsync low cycles so far

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            low_run <= '0;
        end else begin
            low_run <= hsync ? 8'd0 : low_run + 8'd1;
        end
    end

    // ----------------------------------------------------------------------
    // sync and active rules
    // ----------------------------------------------------------------------
    hsync_width: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        $rose(hsync) |-> low_run == 8'(`HSYNC_LEN * 2))
        else $error("hsync was low for %0d cycles", low_run);

    // no picture during any sync pulse
    active_in_sync: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        active |-> (hsync && vsync))
        else $error("active high during hsync or vsync");

    sync_in_reset: assert property (@(posedge clk_dot4x)
        (!rst_n && $past(!rst_n)) |-> (hsync && vsync && csync))
        else $error("sync output low during reset");

endmodule : video_top_asserts

bind video_top video_top_asserts i_video_top_asserts (
    .clk_dot4x (clk_dot4x),
    .rst_n     (rst_n),
    .hsync     (hsync),
    .vsync     (vsync),
    .csync     (csync),
    .active    (active)
);

//--- source/video_top.sv
`timescale 1ns/1ps

`include "vic_defines.svh"

module video_top (
    input  logic                clk_dot4x,
    input  logic                rst_n,
    input  logic                is_composite,   // high composite, low vga/hdmi
    input  vic_pkg::chip_t      chip,           // held stable outside reset
    input  logic [3:0]          border_color,
    output logic                csync,
    output logic                hsync,
    output logic                vsync,
    output logic                active,
    output logic [2:0]          red,
    output logic [2:0]          green,
    output logic [2:0]          blue,
    output logic [`X_BITS-1:0]  raster_x,       // observation only
    output logic [`Y_BITS-1:0]  raster_line
);

    logic                dot_we;
    logic [3:0]          pixel_color3;
    logic [`X_BITS-1:0]  rd_addr;
    logic                rd_bank;
    logic [3:0]          rd_data;
    logic [3:0]          pixel_color4_composite;
    logic [3:0]          pixel_color4_vga;
    logic [3:0]          out_pixel;

    // ----------------------------------------------------------------------
    // raster source and scan doubler
    // ----------------------------------------------------------------------
    raster_gen i_raster_gen (
        .clk_dot4x    (clk_dot4x),
        .rst_n        (rst_n),
        .chip         (chip),
        .border_color (border_color),
        .dot_we       (dot_we),
        .raster_x     (raster_x),
        .raster_line  (raster_line),
        .pixel_color3 (pixel_color3)
    );

    line_buffer i_line_buffer (
        .clk_dot4x (clk_dot4x),
        .we        (dot_we),
        .wr_bank   (raster_line[0]),    // bank follows line parity
        .wr_addr   (raster_x),
        .wr_data   (pixel_color3),
        .rd_bank   (rd_bank),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // ----------------------------------------------------------------------
    // sync generators
    // ----------------------------------------------------------------------
    vga_sync i_vga_sync (
        .clk_dot4x        (clk_dot4x),
        .rst_n            (rst_n),
        .chip             (chip),
        .raster_line      (raster_line),
        .rd_data          (rd_data),
        .rd_addr          (rd_addr),
        .rd_bank          (rd_bank),
        .hsync            (hsync),
        .vsync            (vsync),
        .active           (active),
        .pixel_color4_vga (pixel_color4_vga)
    );

    comp_sync i_comp_sync (
        .clk_dot4x    (clk_dot4x),
        .rst_n        (rst_n),
        .chip         (chip),
        .raster_x     (raster_x),
        .raster_y     (raster_line),
        .pixel_color3 (pixel_color3),
        .csync        (csync),
        .pixel_color4 (pixel_color4_composite)
    );

    // output stream picked by video type
    assign out_pixel = is_composite ? pixel_color4_composite : pixel_color4_vga;

    color i_color (
        .out_pixel (out_pixel),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule : video_top

//--- source/color.sv
`timescale 1ns/1ps

module color (
    input  logic [3:0] out_pixel,   // palette index
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [2:0] blue
);

    // ----------------------------------------------------------------------
    // c64 palette reduced to 3 bits per channel
    // ----------------------------------------------------------------------
    always_comb begin
        case (out_pixel)
            4'd0:    {red, green, blue} = {3'd0, 3'd0, 3'd0};  // black
            4'd1:    {red, green, blue} = {3'd7, 3'd7, 3'd7};  // white
            4'd2:    {red, green, blue} = {3'd4, 3'd0, 3'd0};  // red
            4'd3:    {red, green, blue} = {3'd5, 3'd7, 3'd7};  // cyan
            4'd4:    {red, green, blue} = {3'd6, 3'd2, 3'd6};  // purple
            4'd5:    {red, green, blue} = {3'd0, 3'd6, 3'd2};  // green
            4'd6:    {red, green, blue} = {3'd0, 3'd0, 3'd5};  // blue
            4'd7:    {red, green, blue} = {3'd7, 3'd7, 3'd3};  // yellow
            4'd8:    {red, green, blue} = {3'd6, 3'd4, 3'd2};  // orange
            4'd9:    {red, green, blue} = {3'd3, 3'd2, 3'd0};  // brown
            4'd10:   {red, green, blue} = {3'd7, 3'd3, 3'd3};  // light red
            4'd11:   {red, green, blue} = {3'd1, 3'd1, 3'd1};  // dark grey
            4'd12:   {red, green, blue} = {3'd3, 3'd3, 3'd3};  // mid grey
            4'd13:   {red, green, blue} = {3'd5, 3'd7, 3'd3};  // light green
            4'd14:   {red, green, blue} = {3'd0, 3'd4, 3'd7};  // light blue
            default: {red, green, blue} = {3'd5, 3'd5, 3'd5};  // light grey
        endcase
    end

endmodule : color

//--- source/comp_sync.sv
`timescale 1ns/1ps

`include "vic_defines.svh"

module comp_sync (
    input  logic                clk_dot4x,
    input  logic                rst_n,
    input  vic_pkg::chip_t      chip,
    input  logic [`X_BITS-1:0]  raster_x,
    input  logic [`Y_BITS-1:0]  raster_y,
    input  logic [3:0]          pixel_color3,
    output logic                csync,
    output logic [3:0]          pixel_color4
);
    import vic_pkg::*;

    vsync_state_t        state;
    vsync_state_t        state_next;
    logic [`X_BITS-1:0]  half_x;     // serration half a line after hsync
    logic                in_hsync;
    logic                in_serr;
    logic                sync_low;

    assign half_x = (chip == CHIP_6567_NTSC)
                  ? `X_BITS'(`HSYNC_START - `NTSC_DOTS_PER_LINE / 2)
                  : `X_BITS'(`HSYNC_START - `PAL_DOTS_PER_LINE / 2);

    assign in_hsync = (raster_x >= `X_BITS'(`HSYNC_START)) &&
                      (raster_x < `X_BITS'(`HSYNC_START + `HSYNC_LEN));
    assign in_serr  = (raster_x >= half_x) && (raster_x < half_x + `X_BITS'(`HSYNC_LEN / 2));

    // ----------------------------------------------------------------------
    // line state FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            SYNC_NORMAL:
                if (raster_y == `Y_BITS'(`VSYNC_LINE)) state_next = SYNC_EQUALIZE;
            SYNC_EQUALIZE: begin
                if (raster_y == `Y_BITS'(`VSYNC_LINE + 1)) begin
                    state_next = SYNC_VERTICAL;
                end else if (raster_y == `Y_BITS'(`VSYNC_LINE + `VSYNC_LEN)) begin
                    state_next = SYNC_NORMAL;           // vsync over
                end
            end
            SYNC_VERTICAL:
                if (raster_y == `Y_BITS'(`VSYNC_LINE + `VSYNC_LEN - 1)) state_next = SYNC_EQUALIZE;
            default:
                state_next = SYNC_NORMAL;
        endcase
    end

    // pulse shape of this line
    always_comb begin
        case (state_next)
            SYNC_EQUALIZE: sync_low = !(in_hsync || in_serr);
            SYNC_VERTICAL: sync_low = !in_hsync;        // inverted pulse
            default:       sync_low = in_hsync;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            state <= SYNC_NORMAL;
            csync <= 1'b1;
        end else begin
            state <= state_next;
            csync <= ~sync_low;
        end
    end

    // blank during the pulse and the top lines
    always_ff @(posedge clk_dot4x) begin
        pixel_color4 <= (in_hsync || (raster_y < `Y_BITS'(`VISIBLE_Y_START))) ? 4'd0
                                                                              : pixel_color3;
    end

endmodule : comp_sync

//--- source/vga_sync.sv
`timescale 1ns/1ps

`include "vic_defines.svh"

module vga_sync (
    input  logic                clk_dot4x,
    input  logic                rst_n,
    input  vic_pkg::chip_t      chip,
    input  logic [`Y_BITS-1:0]  raster_line,
    input  logic [3:0]          rd_data,
    output logic [`X_BITS-1:0]  rd_addr,
    output logic                rd_bank,
    output logic                hsync,
    output logic                vsync,
    output logic                active,
    output logic [3:0]          pixel_color4_vga
);
    import vic_pkg::*;

    logic                half;       // divide-by-2 enable
    logic [`X_BITS-1:0]  vga_x;      // dot position on the doubled line
    logic [`X_BITS-1:0]  x_last;
    logic [`Y_BITS-1:0]  line_q;     // source line seen last cycle
    logic                line_start;
    logic                hs_c;
    logic                vs_c;
    logic                act_c;
    logic [1:0]          hs_d;       // covers the address register and buffer read
    logic [1:0]          vs_d;
    logic [1:0]          act_d;

    assign x_last = (chip == CHIP_6567_NTSC) ? `X_BITS'(`NTSC_DOTS_PER_LINE - 1)
                                             : `X_BITS'(`PAL_DOTS_PER_LINE - 1);

    assign line_start = (raster_line != line_q);   // new source line began

    // ----------------------------------------------------------------------
    // sync and active decode from the doubled counter
    // ----------------------------------------------------------------------
    assign hs_c  = (vga_x >= `X_BITS'(`HSYNC_START)) &&
                   (vga_x < `X_BITS'(`HSYNC_START + `HSYNC_LEN));
    assign vs_c  = (raster_line - `Y_BITS'(`VSYNC_LINE)) < `Y_BITS'(`VSYNC_LEN);
    assign act_c = (vga_x < `X_BITS'(`VISIBLE_X)) &&
                   (raster_line >= `Y_BITS'(`VISIBLE_Y_START)) &&
                   (raster_line <= `Y_BITS'(`VISIBLE_Y_END));

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            half    <= 1'b0;
            vga_x   <= '0;
            line_q  <= '0;
            rd_addr <= '0;
            rd_bank <= 1'b0;
            hs_d    <= 2'b00;
            vs_d    <= 2'b00;
            act_d   <= 2'b00;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            active  <= 1'b0;
        end else begin
            line_q <= raster_line;
            if (line_start) begin                   // lock phase to the source line
                half  <= 1'b0;
                vga_x <= '0;
            end else begin
                half <= ~half;
                if (half) begin
                    vga_x <= (vga_x == x_last) ? '0 : vga_x + 1'b1;
                end
            end
            rd_addr <= vga_x;
            rd_bank <= ~raster_line[0];             // previous line's bank
            hs_d    <= {hs_d[0], hs_c};
            vs_d    <= {vs_d[0], vs_c};
            act_d   <= {act_d[0], act_c};
            hsync   <= ~hs_d[1];                    // active low
            vsync   <= ~vs_d[1];
            active  <= act_d[1];
        end
    end

    // black outside the active area
    always_ff @(posedge clk_dot4x) begin
        pixel_color4_vga <= act_d[1] ? rd_data : 4'd0;
    end

endmodule : vga_sync

//--- source/line_buffer.sv
`timescale 1ns/1ps

`include "vic_defines.svh"

module line_buffer (
    input  logic                clk_dot4x,
    input  logic                we,         // one write per dot
    input  logic                wr_bank,    // line parity being drawn
    input  logic [`X_BITS-1:0]  wr_addr,
    input  logic [3:0]          wr_data,
    input  logic                rd_bank,    // the other bank
    input  logic [`X_BITS-1:0]  rd_addr,
    output logic [3:0]          rd_data
);

    // ----------------------------------------------------------------------
    // ping-pong pair of line memories
    // ----------------------------------------------------------------------
    logic [3:0] mem_even [0:(1 << `X_BITS) - 1];   // even source lines
    logic [3:0] mem_odd  [0:(1 << `X_BITS) - 1];   // odd source lines

    // write side runs at dot rate
    always_ff @(posedge clk_dot4x) begin
        if (we) begin
            if (wr_bank) begin
                mem_odd[wr_addr] <= wr_data;
            end else begin
                mem_even[wr_addr] <= wr_data;
            end
        end
    end

    // read side at double rate
    // each stored line is read out twice by the vga side
    always_ff @(posedge clk_dot4x) begin
        if (rd_bank) begin
            rd_data <= mem_odd[rd_addr];
        end else begin
            rd_data <= mem_even[rd_addr];
        end
    end

endmodule : line_buffer

//--- source/raster_gen.sv
`timescale 1ns/1ps

`include "vic_defines.svh"

module raster_gen (
    input  logic                clk_dot4x,
    input  logic                rst_n,
    input  vic_pkg::chip_t      chip,
    input  logic [3:0]          border_color,
    output logic                dot_we,         // first cycle of each dot
    output logic [`X_BITS-1:0]  raster_x,
    output logic [`Y_BITS-1:0]  raster_line,
    output logic [3:0]          pixel_color3
);
    import vic_pkg::*;

    logic [1:0]          phase;     // clk_dot4x cycle within the dot
    logic [`X_BITS-1:0]  x_next;    // position shown on the next strobe
    logic [`Y_BITS-1:0]  y_next;
    logic [`X_BITS-1:0]  x_last;    // last dot of a line
    logic [`Y_BITS-1:0]  y_last;    // last line of a frame
    logic                in_window;
    logic [3:0]          pattern;

    // ----------------------------------------------------------------------
    // geometry from the chip model
    // ----------------------------------------------------------------------
    always_comb begin
        if (chip == CHIP_6567_NTSC) begin
            x_last = `X_BITS'(`NTSC_DOTS_PER_LINE - 1);
            y_last = `Y_BITS'(`NTSC_LINES - 1);
        end else begin
            x_last = `X_BITS'(`PAL_DOTS_PER_LINE - 1);
            y_last = `Y_BITS'(`PAL_LINES - 1);
        end
    end

    // window test on the dot about to be shown
    assign in_window = (x_next >= `X_BITS'(`WIN_X_START)) &&
                       (x_next <= `X_BITS'(`WIN_X_END)) &&
                       (y_next >= `Y_BITS'(`WIN_Y_START)) &&
                       (y_next <= `Y_BITS'(`WIN_Y_END));

    // (x / 8 + line) mod 16
    assign pattern = x_next[6:3] + y_next[3:0];

    // ----------------------------------------------------------------------
    // dot divider and raster counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            phase       <= '0;
            dot_we      <= 1'b0;
            x_next      <= '0;
            y_next      <= '0;
            raster_x    <= '0;
            raster_line <= '0;
        end else begin
            phase  <= (phase == 2'(`DOT_DIV - 1)) ? 2'd0 : phase + 2'd1;
            dot_we <= (phase == 2'd0);          // strobe lines up with the new dot
            if (phase == 2'd0) begin
                raster_x    <= x_next;
                raster_line <= y_next;
                if (x_next == x_last) begin     // end of line
                    x_next <= '0;
                    y_next <= (y_next == y_last) ? '0 : y_next + 1'b1;
                end else begin
                    x_next <= x_next + 1'b1;
                end
            end
        end
    end

    // pixel index follows the counters on the same strobe
    always_ff @(posedge clk_dot4x) begin
        if (phase == 2'd0) begin
            pixel_color3 <= in_window ? pattern : border_color;
        end
    end

endmodule : raster_gen

//--- source/vic_pkg.sv
package vic_pkg;

    // ------------------------------------------------------------------
    // chip model selects the raster geometry
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        CHIP_6569_PAL  = 2'd0,  // 504 dots by 312 lines
        CHIP_6567_NTSC = 2'd1   // 520 dots by 263 lines
    } chip_t;

    // ------------------------------------------------------------------
    // composite sync shape of the current line
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        SYNC_NORMAL   = 2'd0,   // single hsync pulse
        SYNC_EQUALIZE = 2'd1,   // inverted with a serration at half line
        SYNC_VERTICAL = 2'd2    // inverted broad pulse
    } vsync_state_t;

    // lines 0 and 2 equalise and line 1 is the broad vertical line

endpackage : vic_pkg

//--- source/vic_defines.svh
`ifndef VIC_DEFINES_SVH
`define VIC_DEFINES_SVH

// ----------------------------------------------------------------------
// raster geometry per chip model
// ----------------------------------------------------------------------
`define PAL_DOTS_PER_LINE   504
`define NTSC_DOTS_PER_LINE  520
`define PAL_LINES           312
`define NTSC_LINES          263
`define DOT_DIV             4       // clk_dot4x cycles per dot
`define X_BITS              10
`define Y_BITS              9

// display window (320 x 200)
`define WIN_X_START         24
`define WIN_X_END           343
`define WIN_Y_START         51
`define WIN_Y_END           250

// ----------------------------------------------------------------------
// sync positions in dots and source lines
// ----------------------------------------------------------------------
`define HSYNC_START         400
`define HSYNC_LEN           36
`define VSYNC_LINE          0
`define VSYNC_LEN           3       // vsync lasts three source lines
`define VISIBLE_X           384     // vga active width in dots
`define VISIBLE_Y_START     16
`define VISIBLE_Y_END       299

`endif
